// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath width and the address of the first fetch
`define RV_XLEN      32
`define RV_RESET_PC  32'h0000_0000

// Major opcodes, instr[6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// Branch conditions in funct3
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BLT   3'b100
`define RV_F3_BGE   3'b101
`define RV_F3_BLTU  3'b110
`define RV_F3_BGEU  3'b111

// ALU funct3 codes of OP and OP-IMM
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// AxPROT values, bit 2 marks an instruction access
`define RV_AXI_PROT_DATA  3'b000
`define RV_AXI_PROT_INSN  3'b100

// AXI response codes
`define RV_AXI_RESP_OKAY    2'b00
`define RV_AXI_RESP_SLVERR  2'b10

`endif

// File: src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;  // Data word or byte address
    typedef logic [4:0]          reg_addr_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;

    // Operation selected by the decoder for the execute unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // One instruction walks through these states, memory states only for LW and SW
    typedef enum logic [2:0] {
        FETCH_ADDR,
        FETCH_DATA,
        EXECUTE,
        LOAD_ADDR,
        LOAD_DATA,
        STORE_REQ,
        STORE_RESP
    } ctrl_state_e;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_we;    // Opcode writes rd
        word_t     imm;      // Sign-extended I, S, B, U or J immediate
        alu_op_e   alu_op;
        logic      use_imm;  // Operand B is imm instead of rs2
    } dec_t;

    typedef struct packed {
        word_t result;      // Write-back value
        word_t mem_addr;    // ALU sum used as the LW or SW address
        word_t next_pc;
        word_t store_data;
        logic  rd_write;
    } exu_out_t;

    // Address channel payload, shared by AR and AW
    typedef struct packed {
        word_t      addr;
        logic [2:0] prot;
    } axi_ax_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
    } axi_w_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

endpackage

// File: src/rv_idu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_idu (
    input  rv_pkg::word_t instr,
    output rv_pkg::dec_t  dec
);

    import rv_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    f7_bit5;  // Picks SUB over ADD and SRA over SRL

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign f7_bit5 = instr[30];

    always_comb begin
        dec        = '0;
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];

        // Immediate format follows the opcode
        case (opcode)
            `RV_OP_LUI, `RV_OP_AUIPC:
                dec.imm = {instr[31:12], 12'b0};
            `RV_OP_JAL:
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            `RV_OP_BRANCH:
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            `RV_OP_STORE:
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            default:
                dec.imm = {{20{instr[31]}}, instr[31:20]};  // I-type, also JALR and LW
        endcase

        // Only OP and OP-IMM pick an operation, every other opcode adds
        dec.alu_op = ALU_ADD;
        if (opcode == `RV_OP_REG || opcode == `RV_OP_IMM) begin
            case (funct3)
                `RV_F3_ADD:  dec.alu_op = (opcode == `RV_OP_REG && f7_bit5) ? ALU_SUB : ALU_ADD;
                `RV_F3_SLL:  dec.alu_op = ALU_SLL;
                `RV_F3_SLT:  dec.alu_op = ALU_SLT;
                `RV_F3_SLTU: dec.alu_op = ALU_SLTU;
                `RV_F3_XOR:  dec.alu_op = ALU_XOR;
                `RV_F3_SR:   dec.alu_op = f7_bit5 ? ALU_SRA : ALU_SRL;
                `RV_F3_OR:   dec.alu_op = ALU_OR;
                default:     dec.alu_op = ALU_AND;
            endcase
        end

        case (opcode)
            `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR,
            `RV_OP_LOAD, `RV_OP_IMM, `RV_OP_REG:
                dec.rd_we = 1'b1;
            default:
                dec.rd_we = 1'b0;  // Branches, stores and unknown opcodes
        endcase

        // Register-register compares and ALU ops take rs2
        dec.use_imm = (opcode != `RV_OP_REG) && (opcode != `RV_OP_BRANCH);
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    import rv_pkg::*;

    word_t regs [1:31];  // No storage behind x0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;  // A write to x0 is dropped here
        end
    end

    // Reads are combinational, so EXECUTE sees the operands in its own cycle
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/rv_exu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_exu (
    input  rv_pkg::dec_t     dec,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    load_data,
    output rv_pkg::exu_out_t exu
);

    import rv_pkg::*;

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_out;
    word_t      pc_plus4;
    word_t      pc_rel;  // Target of JAL and of every branch
    logic [4:0] shamt;
    logic       branch_taken;

    // Operand A is the pc for AUIPC and zero for LUI, so both reuse the adder
    always_comb begin
        case (dec.opcode)
            `RV_OP_AUIPC: alu_a = pc;
            `RV_OP_LUI:   alu_a = '0;
            default:      alu_a = rs1_data;
        endcase
    end

    assign alu_b = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_out = alu_a - alu_b;
            ALU_SLL:  alu_out = alu_a << shamt;
            ALU_SLT:  alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_out = {31'b0, alu_a < alu_b};
            ALU_XOR:  alu_out = alu_a ^ alu_b;
            ALU_SRL:  alu_out = alu_a >> shamt;
            ALU_SRA:  alu_out = $signed(alu_a) >>> shamt;  // Sign bit fills from the left
            ALU_OR:   alu_out = alu_a | alu_b;
            ALU_AND:  alu_out = alu_a & alu_b;
            default:  alu_out = alu_a + alu_b;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + dec.imm;

    // Branch condition compares the two registers directly
    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  branch_taken = (rs1_data == rs2_data);
            `RV_F3_BNE:  branch_taken = (rs1_data != rs2_data);
            `RV_F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            `RV_F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            `RV_F3_BLTU: branch_taken = (rs1_data < rs2_data);
            `RV_F3_BGEU: branch_taken = (rs1_data >= rs2_data);
            default:     branch_taken = 1'b0;  // 010 and 011 are not branches
        endcase
    end

    always_comb begin
        case (dec.opcode)
            `RV_OP_JAL, `RV_OP_JALR: exu.result = pc_plus4;  // Link value
            `RV_OP_LOAD:             exu.result = load_data;
            default:                 exu.result = alu_out;
        endcase
    end

    // With ALU_ADD and the immediate as operand B the sum is also the LW/SW address
    assign exu.mem_addr = alu_out;

    always_comb begin
        case (dec.opcode)
            `RV_OP_JAL:    exu.next_pc = pc_rel;
            `RV_OP_JALR:   exu.next_pc = {alu_out[31:1], 1'b0};  // rs1 + imm with bit 0 cleared
            `RV_OP_BRANCH: exu.next_pc = branch_taken ? pc_rel : pc_plus4;
            default:       exu.next_pc = pc_plus4;
        endcase
    end

    assign exu.store_data = rs2_data;
    assign exu.rd_write   = dec.rd_we;

endmodule

// File: src/rv_ctrl.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::dec_t     dec,
    input  rv_pkg::exu_out_t exu,
    output rv_pkg::axi_ax_t  ar,
    output logic             ar_valid,
    input  logic             ar_ready,
    input  rv_pkg::axi_r_t   r,
    input  logic             r_valid,
    output logic             r_ready,
    output rv_pkg::axi_ax_t  aw,
    output logic             aw_valid,
    input  logic             aw_ready,
    output rv_pkg::axi_w_t   w,
    output logic             w_valid,
    input  logic             w_ready,
    input  rv_pkg::axi_b_t   b,
    input  logic             b_valid,
    output logic             b_ready,
    output rv_pkg::word_t    pc,
    output rv_pkg::word_t    instr,
    output rv_pkg::word_t    load_data,
    output logic             reg_we
);

    import rv_pkg::*;

    ctrl_state_e state;
    word_t       pc_q;
    word_t       instr_q;
    word_t       load_q;   // Last loaded word, held once the R beat is gone
    logic        is_load;
    logic        is_store;
    logic        ar_hs;
    logic        r_hs;
    logic        aw_done;  // AW finished earlier or finishes this cycle
    logic        w_done;

    assign is_load  = (dec.opcode == `RV_OP_LOAD);
    assign is_store = (dec.opcode == `RV_OP_STORE);
    assign ar_hs    = ar_valid && ar_ready;
    assign r_hs     = r_valid && r_ready;
    assign aw_done  = !aw_valid || aw_ready;
    assign w_done   = !w_valid || w_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= FETCH_ADDR;
            pc_q     <= `RV_RESET_PC;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
        end else begin
            case (state)
                FETCH_ADDR: begin
                    if (ar_hs) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= FETCH_DATA;
                    end else begin
                        ar_valid <= 1'b1;  // Only the first fetch after reset raises it here
                    end
                end
                FETCH_DATA: begin
                    if (r_hs) begin
                        r_ready <= 1'b0;
                        state   <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    ar_valid <= !is_store;  // Data read or the next fetch, both on AR
                    if (is_load) begin
                        state <= LOAD_ADDR;
                    end else if (is_store) begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= STORE_REQ;
                    end else begin
                        pc_q  <= exu.next_pc;  // ALU, jump, branch and no-op retire here
                        state <= FETCH_ADDR;
                    end
                end
                LOAD_ADDR: begin
                    if (ar_hs) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= LOAD_DATA;
                    end
                end
                LOAD_DATA: begin
                    if (r_hs) begin
                        r_ready  <= 1'b0;
                        ar_valid <= 1'b1;
                        pc_q     <= exu.next_pc;
                        state    <= FETCH_ADDR;
                    end
                end
                STORE_REQ: begin
                    // Each channel drops its valid on its own handshake
                    if (aw_valid && aw_ready) aw_valid <= 1'b0;
                    if (w_valid && w_ready) w_valid <= 1'b0;
                    if (aw_done && w_done) begin
                        b_ready <= 1'b1;
                        state   <= STORE_RESP;
                    end
                end
                STORE_RESP: begin
                    if (b_valid && b_ready) begin  // Response code is not checked
                        b_ready  <= 1'b0;
                        ar_valid <= 1'b1;
                        pc_q     <= exu.next_pc;
                        state    <= FETCH_ADDR;
                    end
                end
                default: state <= FETCH_ADDR;
            endcase
        end
    end

    // Instruction and load word are payload and only change on an R beat
    always_ff @(posedge clk) begin
        if (state == FETCH_DATA && r_hs) instr_q <= r.data;
        if (state == LOAD_DATA && r_hs) load_q <= r.data;
    end

    // R data goes straight to the execute unit in the cycle of the handshake
    assign load_data = (state == LOAD_DATA && r_hs) ? r.data : load_q;

    // Write-back pulses in the cycle an instruction that writes rd completes
    assign reg_we = exu.rd_write &&
                    ((state == EXECUTE && !is_load && !is_store) ||
                     (state == LOAD_DATA && r_hs));

    // AR is shared by fetch and load, prot tells them apart
    assign ar.addr = (state == LOAD_ADDR) ? exu.mem_addr : pc_q;
    assign ar.prot = (state == LOAD_ADDR) ? `RV_AXI_PROT_DATA : `RV_AXI_PROT_INSN;

    assign aw.addr = exu.mem_addr;
    assign aw.prot = `RV_AXI_PROT_DATA;
    assign w.data  = exu.store_data;
    assign w.strb  = 4'hf;  // Word stores only

    assign pc    = pc_q;
    assign instr = instr_q;

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic            clk,
    input  logic            rst_n,
    output rv_pkg::axi_ax_t ar,
    output logic            ar_valid,
    input  logic            ar_ready,
    input  rv_pkg::axi_r_t  r,
    input  logic            r_valid,
    output logic            r_ready,
    output rv_pkg::axi_ax_t aw,
    output logic            aw_valid,
    input  logic            aw_ready,
    output rv_pkg::axi_w_t  w,
    output logic            w_valid,
    input  logic            w_ready,
    input  rv_pkg::axi_b_t  b,
    input  logic            b_valid,
    output logic            b_ready
);

    import rv_pkg::*;

    dec_t     dec;
    exu_out_t exu;
    word_t    pc;
    word_t    instr;
    word_t    load_data;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     reg_we;

    // Sequencer and single AXI4-Lite master for both fetch and data
    rv_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .exu       (exu),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .pc        (pc),
        .instr     (instr),
        .load_data (load_data),
        .reg_we    (reg_we)
    );

    rv_idu i_idu (
        .instr (instr),
        .dec   (dec)
    );

    // Write data is always the execute result, loads included
    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .we       (reg_we),
        .wd       (exu.result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_exu i_exu (
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .pc        (pc),
        .load_data (load_data),
        .exu       (exu)
    );

endmodule

// File: verif/tb_axi_mem.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_axi_mem (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::axi_ax_t ar,
    input  logic            ar_valid,
    output logic            ar_ready,
    output rv_pkg::axi_r_t  r,
    output logic            r_valid,
    input  logic            r_ready,
    input  rv_pkg::axi_ax_t aw,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  rv_pkg::axi_w_t  w,
    input  logic            w_valid,
    output logic            w_ready,
    output rv_pkg::axi_b_t  b,
    output logic            b_valid,
    input  logic            b_ready
);

    import rv_pkg::*;

    word_t  mem [0:1023];    // 4 KiB, word addressed by addr[11:2]
    integer seed = 32'h2a11e216;

    // Ready and valid delays of 0 to 3 cycles
    function automatic int unsigned pick_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    initial begin
        ar_ready = 1'b0;
        r        = '0;
        r_valid  = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b        = '0;
        b_valid  = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h6b00_0000 ^ (i << 2);  // Background depends on the address
        end
    end

    task automatic serve_read();
        word_t addr;
        logic  hs;
        repeat (pick_delay()) @(negedge clk);
        addr     = ar.addr;
        ar_ready = 1'b1;    // Valid is already high, so the handshake is on the next edge
        @(negedge clk);
        ar_ready = 1'b0;
        repeat (pick_delay()) @(negedge clk);
        r.data  = mem[addr[11:2]];
        r.resp  = `RV_AXI_RESP_OKAY;
        r_valid = 1'b1;
        // Ready seen at a falling edge holds through the next rising edge
        do begin
            hs = r_ready;
            @(negedge clk);
        end while (!hs);
        r_valid = 1'b0;
    endtask

    task automatic serve_write();
        word_t addr;
        word_t data;
        logic  hs;
        repeat (pick_delay()) @(negedge clk);
        addr     = aw.addr;
        aw_ready = 1'b1;
        @(negedge clk);
        aw_ready = 1'b0;
        repeat (pick_delay()) @(negedge clk);
        data    = w.data;
        w_ready = 1'b1;
        @(negedge clk);
        w_ready = 1'b0;
        mem[addr[11:2]] = data;
        repeat (pick_delay()) @(negedge clk);
        b.resp  = `RV_AXI_RESP_OKAY;
        b_valid = 1'b1;
        do begin
            hs = b_ready;
            @(negedge clk);
        end while (!hs);
        b_valid = 1'b0;
    endtask

    // The core has at most one transaction open, so one process serves both directions
    always @(negedge clk) begin
        if (rst_n && ar_valid) serve_read();
        else if (rst_n && aw_valid) serve_write();
    end

endmodule

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam word_t RESULT_BASE = 32'h0000_0400;
    localparam int    MAX_CYCLES  = 4000;  // Worst case is near 2000 cycles with every delay at 3

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    axi_ax_t ar, aw;
    axi_w_t  w;
    axi_r_t  r;
    axi_b_t  b;
    logic ar_valid, ar_ready, r_valid, r_ready;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

    word_t prog [$];
    word_t expected [$];  // One word per result slot, in program order
    int    stores_seen = 0;
    int    fetches = 0;
    int    loop_fetches = 0;
    int    cycles = 0;
    word_t prev_fetch = '1;
    word_t jalr_pc, jalr_target, loop_pc, load_addr;

    always #20 clk = ~clk;

    rv_core i_dut (.*);
    tb_axi_mem i_mem (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    // RV32I instruction formats
    function automatic word_t enc_i(word_t imm, int rs1, funct3_t f3, int rd, opcode_t op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, funct3_t f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_REG};
    endfunction

    function automatic word_t enc_b(word_t imm, int rs2, int rs1, funct3_t f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_j(word_t imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
    endfunction

    function automatic word_t here();
        return prog.size() * 4;  // Address of the next emitted word
    endfunction

    task automatic emit(input word_t insn);
        prog.push_back(insn);
    endtask

    task automatic addi(input int rd, input int rs1, input word_t imm);
        emit(enc_i(imm, rs1, `RV_F3_ADD, rd, `RV_OP_IMM));
    endtask

    // Stores rs into the next result slot with x31 as the base
    task automatic store_result(input int rs, input word_t exp);
        word_t off;
        off = expected.size() * 4;
        emit({off[11:5], rs[4:0], 5'd31, 3'b010, off[4:0], `RV_OP_STORE});
        expected.push_back(exp);
    endtask

    // x8 is the marker, set to 1 only when the branch falls through
    task automatic branch_case(input funct3_t f3, input int rs1, input int rs2, input logic taken);
        addi(8, 0, 0);
        emit(enc_b(8, rs2, rs1, f3));
        addi(8, 0, 1);
        store_result(8, taken ? 32'd0 : 32'd1);
    endtask

    task automatic build_program();
        word_t auipc_pc;
        word_t jal_pc;
        addi(1, 0, -7);                                          // x1 = 0xfffffff9
        addi(2, 0, 3);
        addi(31, 0, RESULT_BASE);
        addi(3, 1, 5);
        store_result(3, 32'hffff_fffe);
        emit(enc_i(-6, 1, `RV_F3_SLT, 3, `RV_OP_IMM));
        store_result(3, 32'd1);
        emit(enc_i(-1, 2, `RV_F3_SLTU, 3, `RV_OP_IMM));
        store_result(3, 32'd1);
        emit(enc_i(32'hf0, 1, `RV_F3_XOR, 3, `RV_OP_IMM));
        store_result(3, 32'hffff_ff09);
        emit(enc_i(32'h500, 2, `RV_F3_OR, 3, `RV_OP_IMM));
        store_result(3, 32'h0000_0503);
        emit(enc_i(32'h3c, 1, `RV_F3_AND, 3, `RV_OP_IMM));
        store_result(3, 32'h0000_0038);
        emit(enc_i(4, 1, `RV_F3_SLL, 3, `RV_OP_IMM));
        store_result(3, 32'hffff_ff90);
        emit(enc_i(28, 1, `RV_F3_SR, 3, `RV_OP_IMM));
        store_result(3, 32'h0000_000f);
        emit(enc_i(32'h401, 1, `RV_F3_SR, 3, `RV_OP_IMM));
        store_result(3, 32'hffff_fffc);
        emit(enc_r(7'h00, 2, 1, `RV_F3_ADD, 3));
        store_result(3, 32'hffff_fffc);
        emit(enc_r(7'h20, 1, 2, `RV_F3_ADD, 3));
        store_result(3, 32'h0000_000a);
        emit(enc_r(7'h20, 2, 1, `RV_F3_ADD, 3));
        store_result(3, 32'hffff_fff6);
        emit(enc_r(7'h00, 2, 2, `RV_F3_SLL, 3));
        store_result(3, 32'h0000_0018);
        emit(enc_r(7'h00, 2, 1, `RV_F3_SLT, 3));
        store_result(3, 32'd1);
        emit(enc_r(7'h00, 2, 1, `RV_F3_SLTU, 3));
        store_result(3, 32'd0);
        emit(enc_r(7'h00, 2, 1, `RV_F3_XOR, 3));
        store_result(3, 32'hffff_fffa);
        emit(enc_r(7'h00, 2, 1, `RV_F3_SR, 3));
        store_result(3, 32'h1fff_ffff);
        emit(enc_r(7'h20, 2, 1, `RV_F3_SR, 3));
        store_result(3, 32'hffff_ffff);
        emit(enc_r(7'h00, 2, 1, `RV_F3_OR, 3));
        store_result(3, 32'hffff_fffb);
        emit(enc_r(7'h00, 2, 1, `RV_F3_AND, 3));
        store_result(3, 32'h0000_0001);
        emit({20'h12345, 5'd4, `RV_OP_LUI});
        store_result(4, 32'h1234_5000);
        auipc_pc = here();
        emit({20'h00001, 5'd4, `RV_OP_AUIPC});
        store_result(4, auipc_pc + 32'h0000_1000);
        // JAL skips one word that would clobber the link register
        jal_pc = here();
        emit(enc_j(8, 5));
        addi(5, 0, 0);
        store_result(5, jal_pc + 4);
        // JALR to an odd address must clear bit 0
        jalr_pc     = here() + 4;
        jalr_target = here() + 12;
        addi(7, 0, jalr_target + 1);
        emit(enc_i(0, 7, 3'b000, 5, `RV_OP_JALR));
        addi(5, 0, 0);
        store_result(5, jalr_pc + 4);
        branch_case(`RV_F3_BEQ, 2, 2, 1'b1);
        branch_case(`RV_F3_BEQ, 1, 2, 1'b0);
        branch_case(`RV_F3_BNE, 1, 2, 1'b1);
        branch_case(`RV_F3_BNE, 2, 2, 1'b0);
        branch_case(`RV_F3_BLT, 1, 2, 1'b1);                     // -7 < 3
        branch_case(`RV_F3_BLT, 2, 1, 1'b0);
        branch_case(`RV_F3_BGE, 2, 1, 1'b1);
        branch_case(`RV_F3_BGE, 1, 2, 1'b0);
        branch_case(`RV_F3_BLTU, 2, 1, 1'b1);                    // 3 < 0xfffffff9
        branch_case(`RV_F3_BLTU, 1, 2, 1'b0);
        branch_case(`RV_F3_BGEU, 1, 2, 1'b1);
        branch_case(`RV_F3_BGEU, 2, 1, 1'b0);
        // SW then LW of the same slot
        emit({20'hcafeb, 5'd9, `RV_OP_LUI});
        store_result(9, 32'hcafe_b000);
        load_addr = RESULT_BASE + (expected.size() - 1) * 4;
        emit(enc_i(load_addr - RESULT_BASE, 31, 3'b010, 10, `RV_OP_LOAD));
        store_result(10, 32'hcafe_b000);
        addi(0, 0, 55);                                          // x0 stays zero
        emit(enc_r(7'h00, 2, 1, `RV_F3_ADD, 0));
        store_result(0, 32'd0);
        loop_pc = here();
        emit(enc_j(0, 0));
    endtask

    // Handshakes sampled at the rising edge, before the core updates
    always @(posedge clk) begin
        if (rst_n && aw_valid && aw_ready) begin
            assert (aw.prot == `RV_AXI_PROT_DATA)
            else stop_run($sformatf("Mismatch aw.prot at %h: actual %h expected %h",
                                    aw.addr, aw.prot, `RV_AXI_PROT_DATA));
        end
        if (rst_n && w_valid && w_ready) begin
            assert (aw.addr >= RESULT_BASE && aw.addr < RESULT_BASE + expected.size() * 4)
            else stop_run($sformatf("Store to an unexpected address %h", aw.addr));
            assert ((aw.addr - RESULT_BASE) >> 2 == stores_seen)
            else stop_run($sformatf("Store to %h arrived out of program order", aw.addr));
            assert (w.strb == 4'hf)
            else stop_run($sformatf("Mismatch w.strb at %h: actual %h expected %h",
                                    aw.addr, w.strb, 4'hf));
            assert (w.data == expected[stores_seen])
            else stop_run($sformatf("Mismatch w.data at %h: actual %h expected %h",
                                    aw.addr, w.data, expected[stores_seen]));
            stores_seen++;
        end
        if (rst_n && ar_valid && ar_ready && ar.prot == `RV_AXI_PROT_INSN) begin
            if (fetches == 0) begin
                assert (ar.addr == `RV_RESET_PC)
                else stop_run($sformatf("Mismatch ar.addr first fetch: actual %h expected %h",
                                        ar.addr, `RV_RESET_PC));
            end
            assert (ar.addr < prog.size() * 4)
            else stop_run($sformatf("Instruction fetch from %h outside the program", ar.addr));
            if (prev_fetch == jalr_pc) begin
                assert (ar.addr == jalr_target)
                else stop_run($sformatf("Mismatch ar.addr after JALR: actual %h expected %h",
                                        ar.addr, jalr_target));
            end
            if (ar.addr == loop_pc) loop_fetches++;
            prev_fetch = ar.addr;
            fetches++;
        end else if (rst_n && ar_valid && ar_ready) begin
            assert (fetches != 0)
            else stop_run("The first read after reset is not an instruction fetch");
            // The only data read of the program is the LW
            assert (ar.prot == `RV_AXI_PROT_DATA && ar.addr == load_addr)
            else stop_run($sformatf("Mismatch ar of LW: actual %h/%h expected %h/%h",
                                    ar.addr, ar.prot, load_addr, `RV_AXI_PROT_DATA));
        end
    end

    assert property (@(negedge clk)
                     !rst_n |-> !(ar_valid || aw_valid || w_valid || r_ready || b_ready))
    else stop_run("A valid or ready output is high during reset");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)))
    else stop_run("AR valid or payload changed while ready was low");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)))
    else stop_run("AW valid or payload changed while ready was low");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (w_valid && !w_ready) |=> (w_valid && $stable(w)))
    else stop_run("W valid or payload changed while ready was low");

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) stop_run("Timeout, the program did not finish in time");
    end

    initial begin
        build_program();
        @(negedge clk);
        foreach (prog[i]) i_mem.mem[i] = prog[i];
        repeat (4) @(negedge clk);
        rst_n = 1'b1;  // Reset held over 5 rising edges
        while (!(stores_seen == expected.size() && loop_fetches >= 2)) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/rv_pkg.sv
src/rv_idu.sv
src/rv_regfile.sv
src/rv_exu.sv
src/rv_ctrl.sv
src/rv_core.sv
verif/tb_axi_mem.sv
verif/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the core with its testbench in Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_rv_core \
    -Mdir obj_dir -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_rv_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
